// File: verilog.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/operand_bypass.sv
rtl/exec_lane.sv
rtl/writeback_stage.sv
rtl/exec_backend.sv
tests/exec_backend_checker.sv
tests/exec_backend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the back end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f verilog.f \
    --top-module exec_backend_tb

# Keep running past assertion errors so the testbench prints its verdict
output=$(./obj_dir/Vexec_backend_tb +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: tests/exec_backend_tb.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_backend_tb;
    import exec_pkg::*;

    localparam logic [31:0] LOAD_KEY = 32'h5A5A_A5A5;     // Load data is address ^ key

    typedef struct packed {
        logic [`EXEC_RADDR_W-1:0]   waddr;
        logic [`EXEC_XLEN-1:0]      wdata;
        logic [31:0]                cyc;                // Cycle of acceptance
        logic [31:0]                stalls;             // Stall cycles seen by then
    } exp_t;

    logic                               clk;
    logic                               rst;
    issue_t [`EXEC_LANES-1:0]           issue;
    logic                               stall;
    logic                               mem_rvalid;
    logic [`EXEC_XLEN-1:0]              mem_addr;
    logic                               mem_rready;
    logic [`EXEC_XLEN-1:0]              mem_rdata;
    wb_t [`EXEC_LANES-1:0]              wb;

    logic [31:0]                        lfsr_q = 32'd98764;
    logic [`EXEC_XLEN-1:0]              arch [32];          // Updated at issue in program order
    logic [`EXEC_XLEN-1:0]              committed [32];     // Updated at write-back
    exp_t                               exp_a[$];
    exp_t                               exp_b[$];
    logic [`EXEC_RADDR_W-1:0]           last_load_dest = '0;
    logic [31:0]                        cyc = '0;
    logic [31:0]                        stall_cnt = '0;
    logic                               stall_prev = 1'b0;
    int                                 checks = 0;
    int                                 mismatches = 0;
    int                                 other_errors = 0;

    exec_backend dut (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .stall      (stall),
        .mem_rvalid (mem_rvalid),
        .mem_addr   (mem_addr),
        .mem_rready (mem_rready),
        .mem_rdata  (mem_rdata),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            NOR:     return ~a & ~b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            SLT:     return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            SLTU:    return {31'b0, a < b};
            LUI:     return b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] arch_read(input logic [4:0] r);
        return (r == 5'd0) ? 32'h0 : arch[r];
    endfunction

    function automatic issue_t make_item(input int lane, input logic [4:0] a_dest,
                                         input logic allow_load);
        issue_t     it;
        logic [1:0] s1;
        it        = '0;
        it.valid  = (rand_bits(3) != 0);
        it.pc     = rand_bits(30) << 2;
        it.imm    = rand_bits(32);
        it.raddr1 = 5'(rand_bits(3));                       // Small pool for many hazards
        it.raddr2 = 5'(rand_bits(3));
        s1        = 2'(rand_bits(2));
        it.sel1   = (s1 == 2'd1) ? IMM : ((s1 == 2'd2) ? PC : REG);
        it.sel2   = (rand_bits(1) != 0) ? IMM : REG;
        it.op     = alu_op_e'(4'(rand_bits(4) % 12));
        it.rf_we  = (rand_bits(3) != 0);
        it.waddr  = 5'(rand_bits(3));
        if (allow_load && rand_bits(2) == 0) begin
            it.is_load = 1'b1;
            it.op      = ADD;
            it.sel1    = REG;
            it.sel2    = IMM;
            it.rf_we   = 1'b1;
        end
        if (lane == 1) begin                                // B is independent of A
            if (it.raddr1 == a_dest) it.raddr1 = '0;
            if (it.raddr2 == a_dest) it.raddr2 = '0;
            if (it.waddr == a_dest) it.waddr = it.waddr ^ 5'd1;
        end
        if (it.raddr1 == last_load_dest) it.raddr1 = '0;  // Load data not forwardable
        if (it.raddr2 == last_load_dest) it.raddr2 = '0;
        it.rdata1 = committed[it.raddr1];
        it.rdata2 = committed[it.raddr2];
        return it;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finish_run;
        int fails;
        fails = mismatches + other_errors + dut.u_checker.assert_fails;
        $display("checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 checks, mismatches, other_errors, dut.u_checker.assert_fails);
        if (fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic expect_item(input int lane, input issue_t it);
        logic [31:0] s1;
        logic [31:0] s2;
        exp_t        e;
        s1 = (it.sel1 == IMM) ? it.imm : ((it.sel1 == PC) ? it.pc : arch_read(it.raddr1));
        s2 = (it.sel2 == IMM) ? it.imm : arch_read(it.raddr2);
        e.wdata = alu_model(it.op, s1, s2);
        if (lane == `EXEC_LOAD_LANE) begin                  // Load request leaves from EX
            check_value("mem_rvalid", 32'(mem_rvalid), 32'(it.valid && it.is_load));
            if (it.valid && it.is_load) begin
                check_value("mem_addr", mem_addr, e.wdata);
            end
        end
        if (it.is_load) e.wdata = e.wdata ^ LOAD_KEY;
        e.waddr  = it.waddr;
        e.cyc    = cyc;
        e.stalls = stall_cnt;
        if (it.valid && it.rf_we && it.waddr != '0) begin
            arch[it.waddr] = e.wdata;
            if (lane == 0) exp_a.push_back(e);
            else exp_b.push_back(e);
        end
    endtask

    // Drive a pair and hold it until the pipeline takes it
    task automatic issue_pair(input issue_t a, input issue_t b);
        int waited;
        waited   = 0;
        issue[0] = a;
        issue[1] = b;
        @(negedge clk);
        while (stall !== 1'b0) begin
            waited++;
            if (waited > 20) report_timeout("an issued pair to be accepted");
            @(negedge clk);
        end
        #1;
        expect_item(0, a);                                  // A is older
        expect_item(1, b);
        last_load_dest = (b.valid && b.is_load) ? b.waddr : '0;
        @(posedge clk);
        #1;
    endtask

    task automatic random_pair;
        issue_t a;
        issue_t b;
        a = make_item(0, '0, 1'b0);
        b = make_item(1, a.waddr, 1'b1);
        issue_pair(a, b);
    endtask

    task automatic mid_reset;
        rst   = 1'b1;
        issue = '0;
        @(negedge clk);                                     // WB entries still retire here
        #1;
        exp_a.delete();
        exp_b.delete();
        arch = committed;
        last_load_dest = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Load port model with random wait states
    initial begin : mem_model
        logic        pending;
        logic [31:0] pend_addr;
        logic [31:0] addr_s;
        logic [31:0] noise;
        logic        took;
        logic        stalled;
        logic        in_rst;
        logic        idle_bit;
        int          delay;
        int          d;
        pending    = 1'b0;
        pend_addr  = '0;
        delay      = 0;
        mem_rready = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            check_value("stall", 32'(stall), 32'(pending && !mem_rready));
            took     = (mem_rvalid === 1'b1);
            stalled  = (stall === 1'b1);
            in_rst   = (rst === 1'b1);
            addr_s   = mem_addr;
            d        = int'(rand_bits(2));
            noise    = rand_bits(32);
            idle_bit = rand_bits(1) != 0;
            @(posedge clk);
            #1;
            if (in_rst) begin
                pending = 1'b0;
            end else if (took) begin
                pending   = 1'b1;
                pend_addr = addr_s;
                delay     = d;
            end else if (stalled) begin
                delay--;                                    // Load still waits in MEM
            end else begin
                pending = 1'b0;
            end
            mem_rready = pending ? (delay == 0) : idle_bit;
            mem_rdata  = pending ? (pend_addr ^ LOAD_KEY) : noise;
        end
    end

    always @(negedge clk) begin : compare
        exp_t e;
        for (int l = 0; l < `EXEC_LANES; l++) begin
            if (wb[l].we === 1'b1) begin
                if (stall_prev) begin
                    other_errors++;
                    $display("write-back on lane %0d in the cycle after a stall", l);
                end
                if ((l == 0 && exp_a.size() == 0) || (l == 1 && exp_b.size() == 0)) begin
                    other_errors++;
                    $display("write-back on lane %0d with nothing in flight", l);
                end else begin
                    if (l == 0) e = exp_a.pop_front();
                    else e = exp_b.pop_front();
                    check_value($sformatf("wb[%0d].waddr", l), 32'(wb[l].waddr), 32'(e.waddr));
                    check_value($sformatf("wb[%0d].wdata", l), wb[l].wdata, e.wdata);
                    check_value($sformatf("wb[%0d] cycle", l), cyc,
                                e.cyc + 32'd2 + (stall_cnt - e.stalls));
                    committed[e.waddr] = e.wdata;
                end
            end
        end
        stall_prev = (stall === 1'b1);
        if (stall === 1'b1) stall_cnt <= stall_cnt + 1;
    end

    initial begin : main
        issue_t a;
        issue_t b;
        int     waited;
        rst   = 1'b1;
        issue = '0;
        committed[0] = '0;
        for (int r = 1; r < 32; r++) begin
            committed[r] = rand_bits(32);
        end
        arch = committed;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Each ALU operation on both lanes, every result written back
        for (int k = 0; k < 12; k++) begin
            a = make_item(0, '0, 1'b0);
            a.op    = alu_op_e'(4'(k));
            a.valid = 1'b1;
            a.rf_we = 1'b1;
            a.waddr = 5'(k % 7 + 1);
            b = make_item(1, a.waddr, 1'b0);
            b.op    = alu_op_e'(4'(k));
            b.valid = 1'b1;
            b.rf_we = 1'b1;
            if (b.waddr == '0) b.waddr = a.waddr ^ 5'd8;    // Nonzero and apart from A
            issue_pair(a, b);
        end

        repeat (300) random_pair();
        mid_reset();
        repeat (200) random_pair();

        issue  = '0;
        waited = 0;
        while (exp_a.size() + exp_b.size() != 0) begin
            waited++;
            if (waited > 50) report_timeout("the last write-backs");
            @(posedge clk);
        end
        repeat (4) @(posedge clk);                          // Catch stray write-backs
        finish_run();
    end

endmodule

// File: tests/exec_backend_checker.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_backend_checker (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    stall,
    input  logic                                    mem_rvalid,
    input  exec_pkg::wb_t       [`EXEC_LANES-1:0]   wb
);

    int                         assert_fails = 0;   // Read by the testbench at the end
    logic [`EXEC_LANES-1:0]     wb_we;

    always_comb begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            wb_we[l] = wb[l].we;
        end
    end

    // Pipeline is empty in the cycle after reset
    reset_clears: assert property (@(posedge clk) rst |=> (!stall && wb_we == '0))
        else begin
            assert_fails++;
            $error("stall or write-back active right after reset");
        end

    no_req_in_stall: assert property (@(posedge clk) disable iff (rst) !(mem_rvalid && stall))
        else begin
            assert_fails++;
            $error("load request issued while stalled");
        end

    for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_wb
        waddr_nonzero: assert property (@(posedge clk) disable iff (rst)
                                        wb[l].we |-> (wb[l].waddr != '0))
            else begin
                assert_fails++;
                $error("write-back to r0 on lane %0d", l);
            end
    end

endmodule

bind exec_backend exec_backend_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .mem_rvalid (mem_rvalid),
    .wb         (wb)
);

// File: rtl/exec_backend.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_backend (
    input  logic                                    clk,
    input  logic                                    rst,
    input  exec_pkg::issue_t    [`EXEC_LANES-1:0]   issue,
    output logic                                    stall,
    output logic                                    mem_rvalid,
    output logic [`EXEC_XLEN-1:0]                   mem_addr,
    input  logic                                    mem_rready,
    input  logic [`EXEC_XLEN-1:0]                   mem_rdata,
    output exec_pkg::wb_t       [`EXEC_LANES-1:0]   wb
);
    import exec_pkg::*;

    mem_item_t [`EXEC_LANES-1:0]                    mem_items;
    logic [`EXEC_LANES-1:0][1:0][`EXEC_XLEN-1:0]    fwd_rdata;
    logic [`EXEC_LANES-1:0]                         ex_load;
    logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]         ex_addr;

    operand_bypass u_bypass (
        .issue      (issue),
        .mem_items  (mem_items),
        .wb         (wb),
        .fwd_rdata  (fwd_rdata)
    );

    for (genvar l = 0; l < `EXEC_LANES; l++) begin : g_lane
        exec_lane u_lane (
            .clk        (clk),
            .rst        (rst),
            .issue      (issue[l]),
            .fwd_rdata  (fwd_rdata[l]),
            .stall      (stall),
            .mem_item   (mem_items[l]),
            .ex_load    (ex_load[l]),
            .ex_addr    (ex_addr[l])
        );
    end

    writeback_stage u_wb (
        .clk        (clk),
        .rst        (rst),
        .mem_items  (mem_items),
        .mem_rready (mem_rready),
        .mem_rdata  (mem_rdata),
        .stall      (stall),
        .wb         (wb)
    );

    // Load request leaves from EX of the load lane
    assign mem_rvalid = ex_load[`EXEC_LOAD_LANE] & ~stall;
    assign mem_addr   = ex_addr[`EXEC_LOAD_LANE];

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module writeback_stage (
    input  logic                                    clk,
    input  logic                                    rst,
    input  exec_pkg::mem_item_t [`EXEC_LANES-1:0]   mem_items,
    input  logic                                    mem_rready,
    input  logic [`EXEC_XLEN-1:0]                   mem_rdata,
    output logic                                    stall,
    output exec_pkg::wb_t       [`EXEC_LANES-1:0]   wb
);
    import exec_pkg::*;

    wb_t [`EXEC_LANES-1:0]                      wb_d;       // Next write ports
    logic [`EXEC_LANES-1:0]                     we_q;
    logic [`EXEC_LANES-1:0][`EXEC_RADDR_W-1:0]  waddr_q;
    logic [`EXEC_LANES-1:0][`EXEC_XLEN-1:0]     wdata_q;

    // Load waits in MEM until the port returns data
    assign stall = mem_items[`EXEC_LOAD_LANE].is_load & ~mem_rready;

    always_comb begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            wb_d[l].we    = mem_items[l].rf_we & ~stall;    // Bubble while stalled
            wb_d[l].waddr = mem_items[l].waddr;
            if ((l == `EXEC_LOAD_LANE) && mem_items[l].is_load) begin
                wb_d[l].wdata = mem_rdata;
            end else begin
                wb_d[l].wdata = mem_items[l].result;
            end
        end
    end

    // MEM/WB registers
    always_ff @(posedge clk) begin
        if (rst) begin
            we_q <= '0;
        end else begin
            for (int l = 0; l < `EXEC_LANES; l++) begin
                we_q[l] <= wb_d[l].we;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            waddr_q[l] <= wb_d[l].waddr;
            wdata_q[l] <= wb_d[l].wdata;
        end
    end

    always_comb begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            wb[l].we    = we_q[l];
            wb[l].waddr = waddr_q[l];
            wb[l].wdata = wdata_q[l];
        end
    end

endmodule

// File: rtl/exec_lane.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_lane (
    input  logic                            clk,
    input  logic                            rst,
    input  exec_pkg::issue_t                issue,
    input  logic [1:0][`EXEC_XLEN-1:0]      fwd_rdata,
    input  logic                            stall,
    output exec_pkg::mem_item_t             mem_item,
    output logic                            ex_load,
    output logic [`EXEC_XLEN-1:0]           ex_addr
);
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic                           held;           // Previous cycle was stalled
    logic [1:0][`EXEC_XLEN-1:0]     ops_q;
    logic [1:0][`EXEC_XLEN-1:0]     ops;
    logic [`EXEC_XLEN-1:0]          src1;
    logic [`EXEC_XLEN-1:0]          src2;
    logic [SHAMT_W-1:0]             shamt;
    logic [`EXEC_XLEN-1:0]          result;
    logic                           ex_we;

    logic                           mem_we_q;
    logic                           mem_load_q;
    logic [`EXEC_RADDR_W-1:0]       mem_waddr_q;
    logic [`EXEC_XLEN-1:0]          mem_result_q;

    // The WB stage empties during a long stall while issue is held with stale
    // register values, so the operands seen in the first stall cycle are kept
    assign ops = held ? ops_q : fwd_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else begin
            held <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            ops_q <= ops;
        end
    end

    always_comb begin
        case (issue.sel1)
            IMM:     src1 = issue.imm;
            PC:      src1 = issue.pc;
            default: src1 = ops[0];                     // REG
        endcase
    end

    assign src2  = (issue.sel2 == IMM) ? issue.imm : ops[1];
    assign shamt = src2[SHAMT_W-1:0];

    always_comb begin
        case (issue.op)
            ADD:     result = src1 + src2;
            SUB:     result = src1 - src2;
            AND:     result = src1 & src2;
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            NOR:     result = ~(src1 | src2);
            SLL:     result = src1 << shamt;
            SRL:     result = src1 >> shamt;
            SRA:     result = $signed(src1) >>> shamt;
            SLT:     result = {{(`EXEC_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            SLTU:    result = {{(`EXEC_XLEN-1){1'b0}}, src1 < src2};
            LUI:     result = src2;
            default: result = '0;
        endcase
    end

    assign ex_we   = issue.valid & issue.rf_we & (issue.waddr != '0);  // r0 writes dropped
    assign ex_load = issue.valid & issue.is_load;
    assign ex_addr = result;

    // EX/MEM register, held while the load port stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_we_q   <= 1'b0;
            mem_load_q <= 1'b0;
        end else if (!stall) begin
            mem_we_q   <= ex_we;
            mem_load_q <= ex_load;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_waddr_q  <= issue.waddr;
            mem_result_q <= result;
        end
    end

    assign mem_item = '{
        rf_we:   mem_we_q,
        waddr:   mem_waddr_q,
        is_load: mem_load_q,
        result:  mem_result_q
    };

endmodule

// File: rtl/operand_bypass.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module operand_bypass (
    input  exec_pkg::issue_t    [`EXEC_LANES-1:0]               issue,
    input  exec_pkg::mem_item_t [`EXEC_LANES-1:0]               mem_items,
    input  exec_pkg::wb_t       [`EXEC_LANES-1:0]               wb,
    output logic [`EXEC_LANES-1:0][1:0][`EXEC_XLEN-1:0]         fwd_rdata
);

    logic [`EXEC_LANES-1:0][1:0][`EXEC_RADDR_W-1:0] raddr;  // Per lane, per source
    logic [`EXEC_LANES-1:0][1:0][`EXEC_XLEN-1:0]    rf_val;

    always_comb begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            raddr[l][0]  = issue[l].raddr1;
            raddr[l][1]  = issue[l].raddr2;
            rf_val[l][0] = issue[l].rdata1;
            rf_val[l][1] = issue[l].rdata2;
        end
    end

    // Sources are checked from lowest to highest priority, so the last
    // match wins: WB A, WB B, MEM A, MEM B
    always_comb begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            for (int s = 0; s < 2; s++) begin
                fwd_rdata[l][s] = rf_val[l][s];             // Default to register file

                for (int p = 0; p < `EXEC_LANES; p++) begin
                    if (wb[p].we && (wb[p].waddr == raddr[l][s])) begin
                        fwd_rdata[l][s] = wb[p].wdata;
                    end
                end

                for (int p = 0; p < `EXEC_LANES; p++) begin
                    if (mem_items[p].rf_we && !mem_items[p].is_load &&
                        (mem_items[p].waddr == raddr[l][s])) begin
                        fwd_rdata[l][s] = mem_items[p].result;  // Load data not here yet
                    end
                end

                if (raddr[l][s] == '0) begin
                    fwd_rdata[l][s] = '0;                   // r0 reads as zero
                end
            end
        end
    end

endmodule

// File: rtl/exec_pkg.sv
`include "exec_defs.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        NOR  = 4'd5,
        SLL  = 4'd6,
        SRL  = 4'd7,
        SRA  = 4'd8,
        SLT  = 4'd9,
        SLTU = 4'd10,
        LUI  = 4'd11                                // Passes second operand through
    } alu_op_e;

    // PC is only meaningful for the first operand
    typedef enum logic [1:0] {
        REG = 2'd0,
        IMM = 2'd1,
        PC  = 2'd2
    } src_sel_e;

    typedef struct packed {
        logic                       valid;
        logic [`EXEC_XLEN-1:0]      pc;
        logic [`EXEC_RADDR_W-1:0]   raddr1;
        logic [`EXEC_RADDR_W-1:0]   raddr2;
        logic [`EXEC_XLEN-1:0]      rdata1;         // Register file value, may be stale
        logic [`EXEC_XLEN-1:0]      rdata2;
        logic [`EXEC_XLEN-1:0]      imm;
        src_sel_e                   sel1;
        src_sel_e                   sel2;
        alu_op_e                    op;
        logic                       rf_we;
        logic [`EXEC_RADDR_W-1:0]   waddr;
        logic                       is_load;
    } issue_t;

    typedef struct packed {
        logic                       rf_we;
        logic [`EXEC_RADDR_W-1:0]   waddr;
        logic                       is_load;
        logic [`EXEC_XLEN-1:0]      result;         // Load address when is_load
    } mem_item_t;

    typedef struct packed {
        logic                       we;
        logic [`EXEC_RADDR_W-1:0]   waddr;
        logic [`EXEC_XLEN-1:0]      wdata;
    } wb_t;

endpackage

// File: rtl/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath and address width
`define EXEC_XLEN 32

// Register file address width
`define EXEC_RADDR_W 5

// Issue lanes, index 0 is A (older), index 1 is B (younger)
`define EXEC_LANES 2

// Lane that owns the load port
`define EXEC_LOAD_LANE 1

`endif
